// File: source/fetch_pkg.sv
// shared types and constants of the instruction fetch stage
// rv32 only, no compressed instructions, so every fetch is one 4-byte word
// bus structs follow the req/gnt/rvalid instruction bus handshake
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // selectors
  ////////////////////////////////////////////////////////////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap target when pc_sel is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // interrupt number, picks the vectored entry
  typedef logic [4:0] irq_id_t;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // address phase, req and addr held until gnt
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_bus_req_t;

  // grant plus in-order response phase
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } instr_bus_rsp_t;

  // one fetched word with the address it came from
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_item_t;

  // return and vector registers from the csr file
  typedef struct packed {
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [31:0] mtvec;
  } csr_vec_t;

  // low byte appended to the aligned boot address
  localparam logic [7:0]  BOOT_OFFSET    = 8'h80;
  // low bits replaced in mtvec and the boot address
  localparam int unsigned VEC_ALIGN_BITS = 8;
  // sequential fetch step
  localparam logic [31:0] INSTR_BYTES    = 32'd4;

endpackage

`default_nettype wire

// File: source/pc_select.sv
// next fetch address mux, purely combinational
// boot address and mtvec are taken as 256-byte aligned, low byte is replaced
// pc_set_i only gates the mtvec init pulse and the selector checks
`timescale 1ns/100ps
`default_nettype none

module pc_select #(
  parameter logic [31:0] dm_halt_addr      = 32'h1A11_0800,
  parameter logic [31:0] dm_exception_addr = 32'h1A11_0808
) (
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  logic [31:0]            boot_addr_i,
  input  logic [31:0]            branch_target_i,
  input  fetch_pkg::csr_vec_t    csr_i,
  input  logic                   pc_set_i,
  output logic [31:0]            fetch_addr_n_o,
  output logic                   mtvec_init_o
);

  import fetch_pkg::*;

  logic [31:0] mtvec_base;
  logic [31:0] exc_pc;

  // mtvec with the mode and low offset bits cleared
  assign mtvec_base = {csr_i.mtvec[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};

  // trap target
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored entry, one word per interrupt number
      EXC_PC_IRQ:     exc_pc = mtvec_base + ({27'b0, irq_id_i} << 2);
      EXC_PC_DBD:     exc_pc = dm_halt_addr;
      EXC_PC_DBG_EXC: exc_pc = dm_exception_addr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = {boot_addr_i[31:VEC_ALIGN_BITS], BOOT_OFFSET};
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n_o = csr_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_n_o = csr_i.depc;
      default: fetch_addr_n_o = {boot_addr_i[31:VEC_ALIGN_BITS], BOOT_OFFSET};
    endcase
  end

  // csr file loads its mtvec reset value on the boot redirect
  assign mtvec_init_o = (pc_mux_i == PC_BOOT) & pc_set_i;

  // checks are only meaningful on a redirect, the mux is free to float otherwise
  always_comb begin
    if (pc_set_i === 1'b1) begin
      a_sel_known: assert final (!$isunknown({pc_mux_i, exc_pc_mux_i}))
        else $error("pc selectors unknown on redirect");
      a_boot_aligned: assert final (pc_mux_i != PC_BOOT ||
                                    boot_addr_i[VEC_ALIGN_BITS-1:0] == '0)
        else $error("boot address not 256-byte aligned");
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_buffer.sv
// prefetch buffer, at most two bus requests outstanding
// new requests only while queued plus outstanding stay below fifo_depth
// a redirect flushes the queue and drops responses of older requests
`timescale 1ns/100ps
`default_nettype none

module fetch_buffer #(
  parameter int unsigned fifo_depth = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      pc_set_i,
  input  logic [31:0]               fetch_addr_n_i,
  input  fetch_pkg::instr_bus_rsp_t bus_rsp_i,
  input  logic                      item_ready_i,
  output fetch_pkg::instr_bus_req_t bus_req_o,
  output logic                      item_valid_o,
  output fetch_pkg::fetch_item_t    item_o,
  output logic                      busy_o
);

  import fetch_pkg::*;

  localparam int unsigned ptr_w = $clog2(fifo_depth);
  localparam int unsigned cnt_w = $clog2(fifo_depth + 1);
  localparam logic [ptr_w-1:0] last_ptr  = ptr_w'(fifo_depth - 1);
  localparam logic [cnt_w:0]   depth_lim = (cnt_w + 1)'(fifo_depth);

  // no fetch until the first redirect sets a start address
  logic              started_q;
  logic              req_en;
  // request side
  logic [31:0]       new_addr;
  logic [31:0]       req_addr_q;
  logic [31:0]       req_addr;
  logic              grant;
  logic [1:0]        out_q;
  logic [1:0]        out_d;
  // responses still owed to the old path after a redirect
  logic [1:0]        discard_q;
  logic [1:0]        discard_d;
  // address of the next kept response
  logic [31:0]       rsp_addr_q;
  logic              push;
  logic              pop;
  // circular queue
  fetch_item_t       queue_q [fifo_depth];
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [ptr_w-1:0]  rd_ptr_q;
  logic [cnt_w-1:0]  cnt_q;
  logic [cnt_w-1:0]  cnt_eff;
  logic [cnt_w:0]    occupancy;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    ptr_inc = (ptr == last_ptr) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign new_addr = {fetch_addr_n_i[31:2], 2'b00};
  assign req_en   = req_i & (started_q | pc_set_i);
  // redirect replaces an ungranted request in the same cycle
  assign req_addr = pc_set_i ? new_addr : req_addr_q;

  // queue is empty as seen from a redirect cycle
  assign cnt_eff   = pc_set_i ? '0 : cnt_q;
  assign occupancy = (cnt_w + 1)'(cnt_eff) + (cnt_w + 1)'(out_q);

  assign bus_req_o.req  = req_en & (out_q < 2'd2) & (occupancy < depth_lim);
  assign bus_req_o.addr = req_addr;
  assign grant          = bus_req_o.req & bus_rsp_i.gnt;

  // every grant is answered by one rvalid
  assign out_d = out_q + {1'b0, grant} - {1'b0, bus_rsp_i.rvalid};

  // all older responses still to come are dropped, one arriving now included
  always_comb begin
    if (pc_set_i) begin
      discard_d = out_q - {1'b0, bus_rsp_i.rvalid};
    end else if (bus_rsp_i.rvalid && discard_q != 2'd0) begin
      discard_d = discard_q - 2'd1;
    end else begin
      discard_d = discard_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
      out_q     <= 2'd0;
      discard_q <= 2'd0;
    end else begin
      started_q <= started_q | pc_set_i;
      out_q     <= out_d;
      discard_q <= discard_d;
    end
  end

  // address only matters once started
  always_ff @(posedge clk_i) begin
    if (grant) begin
      req_addr_q <= req_addr + INSTR_BYTES;
    end else if (pc_set_i) begin
      req_addr_q <= new_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response queue
  ////////////////////////////////////////////////////////////////////////////

  assign push = bus_rsp_i.rvalid & ~pc_set_i & (discard_q == 2'd0);
  // nothing leaves the queue in a redirect cycle
  assign item_valid_o = (cnt_q != '0) & ~pc_set_i;
  assign pop          = item_valid_o & item_ready_i;
  assign item_o       = queue_q[rd_ptr_q];

  // kept responses are sequential from the redirect address
  always_ff @(posedge clk_i) begin
    if (pc_set_i) begin
      rsp_addr_q <= new_addr;
    end else if (push) begin
      rsp_addr_q <= rsp_addr_q + INSTR_BYTES;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{rdata: bus_rsp_i.rdata, addr: rsp_addr_q, err: bus_rsp_i.err};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (pc_set_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  assign busy_o = (out_q != 2'd0) | bus_req_o.req;

  // request address must be clean and word aligned
  a_req_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.req |-> !$isunknown(bus_req_o.addr) && bus_req_o.addr[1:0] == 2'b00)
    else $error("bad instruction request address");

  // a response needs an earlier grant
  a_rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_i.rvalid |-> out_q != 2'd0)
    else $error("rvalid with no request outstanding");

endmodule

`default_nettype wire

// File: source/if_id_reg.sv
// IF-ID pipeline register, frozen while ID stalls
// valid holds until cleared by ID or a redirect
// new pulses for one cycle after each transfer
`timescale 1ns/100ps
`default_nettype none

module if_id_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   item_valid_i,
  input  fetch_pkg::fetch_item_t item_i,
  input  logic                   id_in_ready_i,
  input  logic                   pc_set_i,
  input  logic                   instr_valid_clear_i,
  output logic                   item_ready_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output logic [31:0]            instr_rdata_id_o,
  output logic                   instr_fetch_err_o,
  output logic [31:0]            pc_id_o
);

  logic xfer;
  logic valid_d;

  // ID takes a word whenever it is ready
  assign item_ready_o = id_in_ready_i;
  assign xfer         = item_valid_i & id_in_ready_i;

  // set by a transfer, held until clear
  // a redirect squashes whatever sits in ID
  assign valid_d = ~pc_set_i & (xfer | (instr_valid_id_o & ~instr_valid_clear_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= xfer;
    end
  end

  // payload, loaded only on a transfer
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o  <= item_i.rdata;
      instr_fetch_err_o <= item_i.err;
      pc_id_o           <= item_i.addr;
    end
  end

  // an offered word stays put until ID takes it, unless a redirect flushes it
  a_item_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    item_valid_i && !id_in_ready_i |=> pc_set_i || (item_valid_i && $stable(item_i)))
    else $error("offered fetch item changed before ID took it");

endmodule

`default_nettype wire

// File: source/if_stage_top.sv
// instruction fetch stage, rv32 with 4-byte instructions only
// boot address must be 256-byte aligned, fetch starts at the first pc_set_i
// fifo_depth of 2 or more, debug addresses are fixed at build time
`timescale 1ns/100ps
`default_nettype none

module if_stage_top #(
  parameter logic [31:0] dm_halt_addr      = 32'h1A11_0800,
  parameter logic [31:0] dm_exception_addr = 32'h1A11_0808,
  parameter int unsigned fifo_depth        = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic [31:0]               boot_addr_i,
  // redirect control
  input  logic                      pc_set_i,
  input  fetch_pkg::pc_sel_e        pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e    exc_pc_mux_i,
  input  fetch_pkg::irq_id_t        irq_id_i,
  input  logic [31:0]               branch_target_i,
  input  fetch_pkg::csr_vec_t       csr_i,
  // instruction bus
  output fetch_pkg::instr_bus_req_t instr_req_o,
  input  fetch_pkg::instr_bus_rsp_t instr_rsp_i,
  // to ID
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [31:0]               instr_rdata_id_o,
  output logic                      instr_fetch_err_o,
  output logic [31:0]               pc_id_o,
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  // misc
  output logic [31:0]               pc_if_o,
  output logic                      mtvec_init_o,
  output logic                      if_busy_o
);

  import fetch_pkg::*;

  logic [31:0] fetch_addr_n;
  logic        item_valid;
  logic        item_ready;
  fetch_item_t fetch_item;

  ////////////////////////////////////////////////////////////////////////////
  // address select, buffer, IF-ID register
  ////////////////////////////////////////////////////////////////////////////

  pc_select #(
    .dm_halt_addr      (dm_halt_addr),
    .dm_exception_addr (dm_exception_addr)
  ) u_pc_select (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_i           (csr_i),
    .pc_set_i        (pc_set_i),
    .fetch_addr_n_o  (fetch_addr_n),
    .mtvec_init_o    (mtvec_init_o)
  );

  fetch_buffer #(
    .fifo_depth (fifo_depth)
  ) u_fetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .bus_rsp_i      (instr_rsp_i),
    .item_ready_i   (item_ready),
    .bus_req_o      (instr_req_o),
    .item_valid_o   (item_valid),
    .item_o         (fetch_item),
    .busy_o         (if_busy_o)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .item_valid_i        (item_valid),
    .item_i              (fetch_item),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .item_ready_o        (item_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  // pc of the word at the buffer head
  assign pc_if_o = fetch_item.addr;

endmodule

`default_nettype wire

// File: include/if_stage_tests.svh
// directed tests and check helpers, included inside the testbench module
// tasks start and end just after a falling edge, where inputs are driven
`ifndef IF_STAGE_TESTS_SVH
`define IF_STAGE_TESTS_SVH

// compare one value and log a mismatch at once
task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks_done++;
  if (act !== exp) begin
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    errors++;
    test_errors++;
  end
endtask

task automatic close_test(input string name);
  $display("test %-20s finished with %0d errors", name, test_errors);
  tests_run++;
  test_errors = 0;
endtask

// ID outputs must hold the word fetched from addr
task automatic check_instr(input logic [31:0] addr);
  check_value("pc_id_o", addr, pc_id_o);
  check_value("instr_rdata_id_o", mem_word(addr), instr_rdata_id_o);
  check_value("instr_fetch_err_o", {31'b0, addr == err_addr}, {31'b0, instr_fetch_err_o});
  check_value("instr_valid_id_o", 32'd1, {31'b0, instr_valid_id_o});
endtask

// step falling edges until instr_new_id_o, optionally with random stalls
task automatic wait_new_instr(input bit stall, output bit got);
  int unsigned n;
  logic        ready_prev;
  logic [31:0] pc_prev;
  logic [31:0] data_prev;
  logic        err_prev;
  got = 1'b0;
  n   = 0;
  while (!got && n < wait_limit) begin
    ready_prev = id_in_ready_i;
    pc_prev    = pc_id_o;
    data_prev  = instr_rdata_id_o;
    err_prev   = instr_fetch_err_o;
    @(negedge clk_i);
    n++;
    // a stalled ID keeps its payload and sees no new word
    if (!ready_prev) begin
      check_value("pc_id_o", pc_prev, pc_id_o);
      check_value("instr_rdata_id_o", data_prev, instr_rdata_id_o);
      check_value("instr_fetch_err_o", {31'b0, err_prev}, {31'b0, instr_fetch_err_o});
      check_value("instr_new_id_o", 32'd0, {31'b0, instr_new_id_o});
    end
    got = instr_new_id_o;
    if (stall) begin
      id_in_ready_i = (($random(seed) & 3) != 0);
    end
  end
  if (!got) begin
    $display("no new instruction reached ID within %0d cycles at %0t ns", wait_limit, $time);
    errors++;
    test_errors++;
  end
endtask

// step falling edges until the buffer stops fetching
task automatic wait_fetch_idle(output bit idle);
  int unsigned n;
  idle = 1'b0;
  n    = 0;
  while (!idle && n < wait_limit) begin
    @(negedge clk_i);
    n++;
    idle = !if_busy_o;
  end
  if (!idle) begin
    $display("fetch did not go idle within %0d cycles at %0t ns", wait_limit, $time);
    errors++;
    test_errors++;
  end
endtask

// count words in order from start, stop early if one never comes
task automatic collect_sequence(input logic [31:0] start, input int unsigned count,
                                input bit stall);
  bit got;
  for (int unsigned i = 0; i < count; i++) begin
    wait_new_instr(stall, got);
    if (!got) begin
      break;
    end
    check_instr(start + INSTR_BYTES * i);
  end
  id_in_ready_i = 1'b1;
endtask

// one-cycle redirect, target_addr is the address the rules give for it
task automatic apply_redirect(input pc_sel_e sel, input exc_pc_sel_e exc_sel,
                              input irq_id_t irq, input logic [31:0] target_addr);
  pc_mux_i     = sel;
  exc_pc_mux_i = exc_sel;
  irq_id_i     = irq;
  pc_set_i     = 1'b1;
  #1;
  check_value("mtvec_init_o", {31'b0, sel == PC_BOOT}, {31'b0, mtvec_init_o});
  // a request in the redirect cycle already carries the new address
  if (instr_req_o.req) begin
    check_value("instr_req_o.addr", {target_addr[31:2], 2'b00}, instr_req_o.addr);
  end
  @(negedge clk_i);
  pc_set_i = 1'b0;
  // the old path is squashed in ID
  check_value("instr_valid_id_o", 32'd0, {31'b0, instr_valid_id_o});
  check_value("instr_new_id_o", 32'd0, {31'b0, instr_new_id_o});
  #1;
  check_value("mtvec_init_o", 32'd0, {31'b0, mtvec_init_o});
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic boot_sequence();
  logic [31:0] boot_pc;
  boot_pc = (boot_addr_i & 32'hFFFF_FF00) | 32'h0000_0080;
  // idle until the first redirect
  repeat (3) begin
    @(negedge clk_i);
    check_value("instr_req_o.req", 32'd0, {31'b0, instr_req_o.req});
    check_value("if_busy_o", 32'd0, {31'b0, if_busy_o});
    check_value("instr_valid_id_o", 32'd0, {31'b0, instr_valid_id_o});
    check_value("instr_new_id_o", 32'd0, {31'b0, instr_new_id_o});
    check_value("mtvec_init_o", 32'd0, {31'b0, mtvec_init_o});
  end
  apply_redirect(PC_BOOT, EXC_PC_EXC, '0, boot_pc);
  collect_sequence(boot_pc, 6, 1'b0);
  close_test("boot");
endtask

task automatic redirect_paths();
  branch_target_i = 32'h0000_4000;
  apply_redirect(PC_JUMP, EXC_PC_EXC, '0, branch_target_i);
  collect_sequence(branch_target_i, 3, 1'b0);
  apply_redirect(PC_ERET, EXC_PC_EXC, '0, csr_i.mepc);
  collect_sequence(csr_i.mepc, 3, 1'b0);
  apply_redirect(PC_DRET, EXC_PC_EXC, '0, csr_i.depc);
  collect_sequence(csr_i.depc, 3, 1'b0);
  close_test("redirects");
endtask

task automatic trap_vectors();
  logic [31:0] base;
  // mode bit and low offset are dropped from mtvec
  base = csr_i.mtvec & 32'hFFFF_FF00;
  apply_redirect(PC_EXC, EXC_PC_EXC, '0, base);
  collect_sequence(base, 2, 1'b0);
  apply_redirect(PC_EXC, EXC_PC_IRQ, 5'd5, base + 32'd20);
  collect_sequence(base + 32'd20, 2, 1'b0);
  apply_redirect(PC_EXC, EXC_PC_IRQ, 5'd31, base + 32'd124);
  collect_sequence(base + 32'd124, 2, 1'b0);
  apply_redirect(PC_EXC, EXC_PC_DBD, '0, halt_addr);
  collect_sequence(halt_addr, 2, 1'b0);
  apply_redirect(PC_EXC, EXC_PC_DBG_EXC, '0, exception_addr);
  collect_sequence(exception_addr, 2, 1'b0);
  close_test("trap vectors");
endtask

task automatic back_pressure();
  branch_target_i = 32'h0000_8000;
  apply_redirect(PC_JUMP, EXC_PC_EXC, '0, branch_target_i);
  collect_sequence(branch_target_i, 16, 1'b1);
  close_test("back-pressure");
endtask

task automatic bus_error_and_clear();
  bit idle;
  err_addr        = 32'h0000_9008;
  branch_target_i = 32'h0000_9000;
  apply_redirect(PC_JUMP, EXC_PC_EXC, '0, branch_target_i);
  collect_sequence(branch_target_i, 4, 1'b0);
  // stall ID so that no transfer can set valid again
  id_in_ready_i = 1'b0;
  // the queue fills behind the stalled ID and fetching stops
  wait_fetch_idle(idle);
  if (idle) begin
    // head of the buffer is the word after the one held in ID
    check_value("pc_if_o", 32'h0000_9010, pc_if_o);
  end
  check_value("instr_valid_id_o", 32'd1, {31'b0, instr_valid_id_o});
  instr_valid_clear_i = 1'b1;
  @(negedge clk_i);
  instr_valid_clear_i = 1'b0;
  check_value("instr_valid_id_o", 32'd0, {31'b0, instr_valid_id_o});
  check_value("instr_new_id_o", 32'd0, {31'b0, instr_new_id_o});
  id_in_ready_i = 1'b1;
  // the held word follows without a gap
  collect_sequence(32'h0000_9010, 1, 1'b0);
  err_addr = 32'hFFFF_FFF0;
  close_test("bus error and clear");
endtask

`endif

// File: verification/tb_if_stage.sv
// testbench of the instruction fetch stage, directed tests from if_stage_tests.svh
// memory model grants after 0 to 3 cycles and answers 1 to 2 cycles after the grant
// read data is the address xor a fixed pattern, err is raised for one chosen address
`timescale 1ns/100ps
`default_nettype none

module tb_if_stage;

  import fetch_pkg::*;

  localparam logic [31:0] halt_addr      = 32'h0001_0800;
  localparam logic [31:0] exception_addr = 32'h0001_0808;
  localparam int unsigned depth          = 3;
  localparam int unsigned reset_cycles   = 5;
  // instructions expected over all tests, 20 cycles of budget each
  localparam int unsigned expected_instrs = 46;
  localparam int unsigned watchdog_cycles = expected_instrs * 20 + reset_cycles;
  // cycles a single wait for a new ID instruction may take
  localparam int unsigned wait_limit      = 40;
  localparam logic [31:0] data_pattern    = 32'hA5C3_0F96;

  logic           clk_i;
  logic           rst_ni;
  logic           req_i;
  logic [31:0]    boot_addr_i;
  logic           pc_set_i;
  pc_sel_e        pc_mux_i;
  exc_pc_sel_e    exc_pc_mux_i;
  irq_id_t        irq_id_i;
  logic [31:0]    branch_target_i;
  csr_vec_t       csr_i;
  instr_bus_req_t instr_req_o;
  instr_bus_rsp_t instr_rsp_i;
  logic           instr_valid_id_o;
  logic           instr_new_id_o;
  logic [31:0]    instr_rdata_id_o;
  logic           instr_fetch_err_o;
  logic [31:0]    pc_id_o;
  logic           id_in_ready_i;
  logic           instr_valid_clear_i;
  logic [31:0]    pc_if_o;
  logic           mtvec_init_o;
  logic           if_busy_o;

  integer         seed = 32'h594f;
  int unsigned    errors;
  int unsigned    test_errors;
  int unsigned    checks_done;
  int unsigned    tests_run;
  // memory model state
  logic [31:0]    err_addr;
  int unsigned    cycle;
  int unsigned    gnt_wait;
  logic [31:0]    pending_addr [$];
  int unsigned    pending_due [$];

  if_stage_top #(
    .dm_halt_addr      (halt_addr),
    .dm_exception_addr (exception_addr),
    .fifo_depth        (depth)
  ) u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .boot_addr_i         (boot_addr_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .branch_target_i     (branch_target_i),
    .csr_i               (csr_i),
    .instr_req_o         (instr_req_o),
    .instr_rsp_i         (instr_rsp_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pc_if_o             (pc_if_o),
    .mtvec_init_o        (mtvec_init_o),
    .if_busy_o           (if_busy_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // memory contents as a function of the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    mem_word = addr ^ data_pattern;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // grants and responses are booked at the rising edge, from pre-edge values
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle    = 0;
      gnt_wait = 0;
      pending_addr.delete();
      pending_due.delete();
    end else begin
      cycle = cycle + 1;
      if (instr_rsp_i.rvalid) begin
        void'(pending_addr.pop_front());
        void'(pending_due.pop_front());
      end
      if (instr_req_o.req && instr_rsp_i.gnt) begin
        pending_addr.push_back(instr_req_o.addr);
        // answered in the next cycle or the one after
        pending_due.push_back(cycle + ($random(seed) & 1));
        gnt_wait = $random(seed) & 3;
      end else if (instr_req_o.req && gnt_wait != 0) begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  // bus response driven on the falling edge, one rvalid per cycle in grant order
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rsp_i = '0;
    end else begin
      instr_rsp_i.gnt = (gnt_wait == 0);
      if (pending_addr.size() != 0 && pending_due[0] <= cycle) begin
        instr_rsp_i.rvalid = 1'b1;
        instr_rsp_i.rdata  = mem_word(pending_addr[0]);
        instr_rsp_i.err    = (pending_addr[0] == err_addr);
      end else begin
        instr_rsp_i.rvalid = 1'b0;
        instr_rsp_i.rdata  = '0;
        instr_rsp_i.err    = 1'b0;
      end
    end
  end

  `include "if_stage_tests.svh"

  ////////////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    req_i               = 1'b1;
    boot_addr_i         = 32'h2000_0000;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    irq_id_i            = '0;
    branch_target_i     = '0;
    csr_i               = '{mepc: 32'h0000_5104, depc: 32'h0000_6208, mtvec: 32'h0000_3001};
    instr_rsp_i         = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    err_addr            = 32'hFFFF_FFF0;
    errors              = 0;
    test_errors         = 0;
    checks_done         = 0;
    tests_run           = 0;
    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    boot_sequence();
    redirect_paths();
    trap_vectors();
    back_pressure();
    bus_error_and_clear();
    repeat (4) @(negedge clk_i);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks_done, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
source/fetch_pkg.sv
source/pc_select.sv
source/fetch_buffer.sv
source/if_id_reg.sv
source/if_stage_top.sv
verification/tb_if_stage.sv
